//--- logic/ppc_instr_pkg.sv
// Only the four 32-bit compare encodings are described here. Bit 0 is the MSB, as in the Power ISA.
package ppc_instr_pkg;

    // Primary opcodes.
    localparam logic [0:5] OPCD_CMPLI = 6'd10;
    localparam logic [0:5] OPCD_CMPI  = 6'd11;
    localparam logic [0:5] OPCD_XFORM = 6'd31;

    // Extended opcodes under primary opcode 31.
    localparam logic [0:9] XO_CMP  = 10'd0;
    localparam logic [0:9] XO_CMPL = 10'd32;

    // Immediate compare layout (cmpi, cmpli).
    typedef struct packed {
        logic [0:5]  opcd;
        logic [0:2]  bf;
        logic        rsv;
        logic        l;
        logic [0:4]  ra;
        logic [0:15] imm;
    } d_form_t;

    // Register compare layout (cmp, cmpl).
    typedef struct packed {
        logic [0:5] opcd;
        logic [0:2] bf;
        logic       rsv;
        logic       l;
        logic [0:4] ra;
        logic [0:4] rb;
        logic [0:9] xo;
        logic       rc;
    } x_form_t;

    // One instruction word, read as either form.
    typedef union packed {
        d_form_t d_form;
        x_form_t x_form;
    } instr_word_u;

    // Control word handed to the compare unit.
    typedef struct packed {
        logic cmp_signed;
    } cmp_decode_t;

endpackage

//--- logic/cr_types_pkg.sv
// Condition register of eight 4-bit fields. Field 0 sits in the most significant nibble.
package cr_types_pkg;

    // Number of fields and bits per field.
    localparam int CR_FIELDS     = 8;
    localparam int CR_FIELD_BITS = 4;

    // Full register width.
    localparam int CR_WIDTH = CR_FIELDS * CR_FIELD_BITS;

    // One field, in the order LT, GT, EQ, SO.
    typedef logic [0:CR_FIELD_BITS-1] cr_field_t;

    // Field select, as carried in the BF field.
    typedef logic [0:2] crf_idx_t;

endpackage

//--- logic/cmp_issue_if.sv
// Valid/ready channel. The source holds its payload stable while valid is high and ready is low.
`timescale 1ns/1ps

interface cmp_issue_if
    import ppc_instr_pkg::*;
    import cr_types_pkg::*;
#(
    parameter int RS_ID_WIDTH = 5
);

    logic                   valid;
    logic                   ready;
    logic [0:RS_ID_WIDTH-1] rs_id;
    crf_idx_t               crf;
    logic [0:31]            op1;
    logic [0:31]            op2;
    logic                   so;
    cmp_decode_t            control;

    // Decoder side.
    modport source (
        output valid,
        input  ready,
        output rs_id,
        output crf,
        output op1,
        output op2,
        output so,
        output control
    );

    // Compare unit side.
    modport sink (
        input  valid,
        output ready,
        input  rs_id,
        input  crf,
        input  op1,
        input  op2,
        input  so,
        input  control
    );

endinterface

//--- logic/cmp_done_if.sv
// Result channel. A result retires on an edge where valid and ready are both high.
`timescale 1ns/1ps

interface cmp_done_if
    import cr_types_pkg::*;
#(
    parameter int RS_ID_WIDTH = 5
);

    logic                   valid;
    logic                   ready;
    logic [0:RS_ID_WIDTH-1] rs_id;
    crf_idx_t               crf;
    cr_field_t              result;

    // Compare unit side.
    modport source (
        output valid,
        input  ready,
        output rs_id,
        output crf,
        output result
    );

    // CR file only watches the handshake.
    modport writer (
        input valid,
        input ready,
        input crf,
        input result
    );

endinterface

//--- logic/cmp_decoder.sv
// Purely combinational. Assumes only cmp, cmpl, cmpi and cmpli arrive, and ignores the L bit.
`timescale 1ns/1ps

module cmp_decoder
    import ppc_instr_pkg::*;
#(
    parameter int RS_ID_WIDTH = 5
)(
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  instr_word_u            instr,
    input  logic [0:RS_ID_WIDTH-1] tag,
    input  logic [0:31]            ra_value,
    input  logic [0:31]            rb_value,
    input  logic                   xer_so,
    cmp_issue_if.source            issue
);

    logic [0:31] op2;
    cmp_decode_t control;

    // Operand B and signedness depend on the form.
    always_comb begin
        op2                = rb_value;
        control.cmp_signed = 1'b0;

        case (instr.d_form.opcd)
            OPCD_CMPI: begin
                // SI is sign-extended.
                op2                = {{16{instr.d_form.imm[0]}}, instr.d_form.imm};
                control.cmp_signed = 1'b1;
            end
            OPCD_CMPLI: begin
                // UI is zero-extended.
                op2                = {16'h0000, instr.d_form.imm};
                control.cmp_signed = 1'b0;
            end
            OPCD_XFORM: begin
                op2 = rb_value;
                case (instr.x_form.xo)
                    XO_CMP:  control.cmp_signed = 1'b1;
                    XO_CMPL: control.cmp_signed = 1'b0;
                    default: control.cmp_signed = 1'b0;
                endcase
            end
            default: begin
                op2                = rb_value;
                control.cmp_signed = 1'b0;
            end
        endcase
    end

    // BF sits at the same bits in both forms.
    assign issue.valid   = instr_valid;
    assign issue.rs_id   = tag;
    assign issue.crf     = instr.x_form.bf;
    assign issue.op1     = ra_value;
    assign issue.op2     = op2;
    assign issue.so      = xer_so;
    assign issue.control = control;

    assign instr_ready = issue.ready;

endmodule

//--- logic/cmp_unit.sv
// Two-stage elastic pipeline. It holds up to two compares, with results in acceptance order.
`timescale 1ns/1ps

module cmp_unit
    import ppc_instr_pkg::*;
    import cr_types_pkg::*;
#(
    parameter int RS_ID_WIDTH = 5
)(
    input  logic      clk,
    input  logic      rst,
    cmp_issue_if.sink issue,
    cmp_done_if.source done
);

    // Stage 0 holds the operands.
    logic                   s0_valid;
    logic [0:RS_ID_WIDTH-1] s0_rs_id;
    crf_idx_t               s0_crf;
    logic [0:31]            s0_op1;
    logic [0:31]            s0_op2;
    logic                   s0_so;
    cmp_decode_t            s0_control;

    // Stage 1 holds the finished field.
    logic                   s1_valid;
    logic [0:RS_ID_WIDTH-1] s1_rs_id;
    crf_idx_t               s1_crf;
    cr_field_t              s1_result;

    cr_field_t cmp_result;
    logic      s0_load;
    logic      s1_load;

    // A stage loads when it is empty or its contents move on.
    assign s1_load = ~s1_valid | done.ready;
    assign s0_load = ~s0_valid | s1_load;

    assign issue.ready = s0_load;

    // Compare over 33 bits so one comparator serves both signed and unsigned.
    always_comb begin
        logic signed [0:32] lhs;
        logic signed [0:32] rhs;

        lhs = {s0_control.cmp_signed & s0_op1[0], s0_op1};
        rhs = {s0_control.cmp_signed & s0_op2[0], s0_op2};

        if (lhs < rhs) begin
            cmp_result[0:2] = 3'b100;
        end else if (lhs > rhs) begin
            cmp_result[0:2] = 3'b010;
        end else begin
            cmp_result[0:2] = 3'b001;
        end
        cmp_result[3] = s0_so;
    end

    // Occupancy flags.
    always_ff @(posedge clk) begin
        if (rst) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
        end else begin
            if (s0_load) begin
                s0_valid <= issue.valid;
            end
            if (s1_load) begin
                s1_valid <= s0_valid;
            end
        end
    end

    // Payload only moves together with a valid entry.
    always_ff @(posedge clk) begin
        if (s0_load && issue.valid) begin
            s0_rs_id   <= issue.rs_id;
            s0_crf     <= issue.crf;
            s0_op1     <= issue.op1;
            s0_op2     <= issue.op2;
            s0_so      <= issue.so;
            s0_control <= issue.control;
        end
        if (s1_load && s0_valid) begin
            s1_rs_id  <= s0_rs_id;
            s1_crf    <= s0_crf;
            s1_result <= cmp_result;
        end
    end

    assign done.valid  = s1_valid;
    assign done.rs_id  = s1_rs_id;
    assign done.crf    = s1_crf;
    assign done.result = s1_result;

endmodule

//--- logic/cr_file.sv
// Only compares write the CR here. A field changes on the edge where its result retires.
`timescale 1ns/1ps

module cr_file
    import cr_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    cmp_done_if.writer        done,
    output logic [0:CR_WIDTH-1] cr
);

    cr_field_t fields [CR_FIELDS];
    logic      retire;

    assign retire = done.valid & done.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            fields <= '{default: '0};
        end else if (retire) begin
            fields[done.crf] <= done.result;
        end
    end

    // Field 0 lands in the top nibble.
    always_comb begin
        for (int i = 0; i < CR_FIELDS; i++) begin
            cr[i*CR_FIELD_BITS +: CR_FIELD_BITS] = fields[i];
        end
    end

endmodule

//--- logic/cmp_subsystem.sv
// 32-bit compares only. The caller supplies RA, RB, SO and a tag with every instruction.
`timescale 1ns/1ps

module cmp_subsystem #(
    parameter int RS_ID_WIDTH = 5
)(
    input  logic                   clk,
    input  logic                   rst,

    // Instruction side.
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  logic [0:31]            instr,
    input  logic [0:RS_ID_WIDTH-1] tag,
    input  logic [0:31]            ra_value,
    input  logic [0:31]            rb_value,
    input  logic                   xer_so,

    // Result side.
    output logic                   done_valid,
    input  logic                   done_ready,
    output logic [0:RS_ID_WIDTH-1] done_tag,
    output logic [0:2]             done_crf,
    output logic [0:3]             done_result,

    // Whole condition register.
    output logic [0:31]            cr
);

    cmp_issue_if #(.RS_ID_WIDTH(RS_ID_WIDTH)) issue_if ();
    cmp_done_if  #(.RS_ID_WIDTH(RS_ID_WIDTH)) done_if ();

    cmp_decoder #(
        .RS_ID_WIDTH (RS_ID_WIDTH)
    ) u_decoder (
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .tag         (tag),
        .ra_value    (ra_value),
        .rb_value    (rb_value),
        .xer_so      (xer_so),
        .issue       (issue_if.source)
    );

    cmp_unit #(
        .RS_ID_WIDTH (RS_ID_WIDTH)
    ) u_unit (
        .clk   (clk),
        .rst   (rst),
        .issue (issue_if.sink),
        .done  (done_if.source)
    );

    cr_file u_cr_file (
        .clk  (clk),
        .rst  (rst),
        .done (done_if.writer),
        .cr   (cr)
    );

    // Result channel out to the ports.
    assign done_if.ready = done_ready;
    assign done_valid    = done_if.valid;
    assign done_tag      = done_if.rs_id;
    assign done_crf      = done_if.crf;
    assign done_result   = done_if.result;

endmodule

//--- dv/cmp_clock_gen.sv
// Free-running clock starting low. The period must be an even number of time units.
`timescale 1ns/1ps

module cmp_clock_gen #(
    parameter int PERIOD_NS = 4
)(
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- dv/cmp_unit_properties.sv
// Bound into cmp_unit and watches its stage registers. Failures also bump prop_errors.
`timescale 1ns/1ps

module cmp_unit_properties
    import cr_types_pkg::*;
#(
    parameter int RS_ID_WIDTH = 5
)(
    input logic                   clk,
    input logic                   rst,
    input logic                   s0_load,
    input logic                   s1_load,
    input logic                   s1_valid,
    input logic [0:RS_ID_WIDTH-1] s1_rs_id,
    input crf_idx_t               s1_crf,
    input cr_field_t              s1_result
);

    int prop_errors = 0;

    // Output stage is empty right after reset.
    assert property (@(posedge clk) rst |=> !s1_valid)
        else begin
            $error("Result valid high in the cycle after reset");
            prop_errors++;
        end

    // A stalled result keeps its payload.
    assert property (@(posedge clk) disable iff (rst)
        (s1_valid && !s1_load) |=>
            (s1_valid && $stable(s1_rs_id) && $stable(s1_crf) && $stable(s1_result)))
        else begin
            $error("Result payload changed while stalled");
            prop_errors++;
        end

    // An empty output stage always leaves room at the input.
    assert property (@(posedge clk) disable iff (rst) !s1_valid |-> s0_load)
        else begin
            $error("Input ready low while the output stage is empty");
            prop_errors++;
        end

endmodule

//--- dv/cmp_tb.sv
// Drives 300 compares through cmp_subsystem. Checks results in order, the CR image and reset.
`timescale 1ns/1ps

module cmp_tb;

    localparam int RS_ID_WIDTH = 5;
    // 300 instructions at up to 4 cycles each, plus resets and drains.
    localparam int MAX_CYCLES = 300 * 4 + 100;
    // A full pipeline empties in a few cycles once done_ready is high.
    localparam int DRAIN_CYCLES = 16;

    typedef struct packed {
        logic [0:RS_ID_WIDTH-1] tag;
        logic [0:2]             crf;
        logic [0:3]             field;
    } exp_t;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid;
    logic                   instr_ready;
    logic [0:31]            instr;
    logic [0:RS_ID_WIDTH-1] tag;
    logic [0:31]            ra_value;
    logic [0:31]            rb_value;
    logic                   xer_so;
    logic                   done_valid;
    logic                   done_ready;
    logic [0:RS_ID_WIDTH-1] done_tag;
    logic [0:2]             done_crf;
    logic [0:3]             done_result;
    logic [0:31]            cr;

    integer                 seed = 53863;
    integer                 ready_seed = 53863;
    logic                   ready_random = 1'b0;
    logic [0:RS_ID_WIDTH-1] next_tag = '0;
    exp_t                   exp_q[$];
    logic [0:3]             seen_results[$];
    logic [0:3]             signed_results[$];
    logic [0:31]            shadow_cr = '0;
    logic [0:31]            pair_a[60];
    logic [0:31]            pair_b[60];
    int                     errors = 0;
    int                     test_errors_start;
    int                     tests_ok = 0;
    int                     tests_bad = 0;
    int                     issued_cnt = 0;
    int                     retired_cnt = 0;
    int                     cycles = 0;

    cmp_clock_gen #(.PERIOD_NS(4)) u_clock (.clk(clk));

    cmp_subsystem #(.RS_ID_WIDTH(RS_ID_WIDTH)) UUT (.*);

    bind cmp_unit cmp_unit_properties #(.RS_ID_WIDTH(RS_ID_WIDTH)) u_props (
        .clk(clk), .rst(rst), .s0_load(s0_load), .s1_load(s1_load), .s1_valid(s1_valid),
        .s1_rs_id(s1_rs_id), .s1_crf(s1_crf), .s1_result(s1_result)
    );

    // Expected CR field from the compare rules of the ISA.
    function automatic logic [0:3] cr_expect(input logic [0:31] word, input logic [0:31] ra,
                                             input logic [0:31] rb, input logic so);
        logic [0:31] b;
        logic        is_signed;
        logic        lt;
        logic        gt;
        if (word[0:5] == 6'd11) begin
            b         = {{16{word[16]}}, word[16:31]};
            is_signed = 1'b1;
        end else if (word[0:5] == 6'd10) begin
            b         = {16'h0000, word[16:31]};
            is_signed = 1'b0;
        end else begin
            b         = rb;
            is_signed = (word[21:30] == 10'd0);
        end
        lt = is_signed ? ($signed(ra) < $signed(b)) : (ra < b);
        gt = is_signed ? ($signed(ra) > $signed(b)) : (ra > b);
        return {lt, gt, !lt && !gt, so};
    endfunction

    function automatic logic [0:31] enc_dform(input logic [0:5] opcd, input logic [0:2] bf,
                                              input logic [0:15] imm);
        return {opcd, bf, 2'b00, 5'd3, imm};
    endfunction

    function automatic logic [0:31] enc_xform(input logic [0:9] xo, input logic [0:2] bf);
        return {6'd31, bf, 2'b00, 5'd3, 5'd4, xo, 1'b0};
    endfunction

    // Holds the word until the unit takes it. Entered and left 1 ns after a rising edge.
    task automatic send_cmp(input logic [0:31] word, input logic [0:31] ra,
                            input logic [0:31] rb, input logic so);
        logic accepted;
        instr_valid = 1'b1;
        instr       = word;
        tag         = next_tag;
        ra_value    = ra;
        rb_value    = rb;
        xer_so      = so;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = instr_ready;
            @(posedge clk);
            #1;
        end
        next_tag = next_tag + 1'b1;
    endtask

    task automatic send_random(input logic so);
        logic [31:0] r;
        r = $random(seed);
        case (r[1:0])
            2'd0: send_cmp(enc_xform(10'd0, r[4:2]), $random(seed), $random(seed), so);
            2'd1: send_cmp(enc_xform(10'd32, r[4:2]), $random(seed), $random(seed), so);
            2'd2: send_cmp(enc_dform(6'd11, r[4:2], r[20:5]), $random(seed), '0, so);
            default: send_cmp(enc_dform(6'd10, r[4:2], r[20:5]), $random(seed), '0, so);
        endcase
    endtask

    task automatic start_test();
        test_errors_start = errors;
        seen_results.delete();
    endtask

    task automatic finish_test(input string name);
        int waited;
        instr_valid = 1'b0;
        waited      = 0;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        repeat (2) @(posedge clk);
        #1;
        assert (issued_cnt == retired_cnt)
            else begin
                $display("%0d instructions accepted but %0d retired", issued_cnt, retired_cnt);
                errors++;
            end
        if (errors == test_errors_start) begin
            $display("Test %s: ok", name);
            tests_ok++;
        end else begin
            $display("Test %s: FAILED with %0d errors", name, errors - test_errors_start);
            tests_bad++;
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // Done ready is always high except in the back-pressure test.
    always @(posedge clk) begin
        #1;
        done_ready = ready_random ? $random(ready_seed) : 1'b1;
    end

    // Scoreboard and shadow CR are sampled mid-cycle where every signal is settled.
    always @(negedge clk) begin
        exp_t e;
        logic exp_ready;
        if (rst) begin
            shadow_cr = '0;
            exp_q.delete();
        end else begin
            // The unit refuses only with two compares in flight and the result stalled.
            exp_ready = !(exp_q.size() >= 2 && !done_ready);
            assert (instr_ready == exp_ready)
                else begin
                    $display("FAIL instr_ready: got %h expected %h", instr_ready, exp_ready);
                    errors++;
                end
            assert (cr == shadow_cr)
                else begin
                    $display("FAIL cr: got %h expected %h", cr, shadow_cr);
                    errors++;
                end
            if (done_valid && done_ready) begin
                if (exp_q.size() == 0) begin
                    $display("A result retired with no instruction outstanding");
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    assert (done_tag == e.tag)
                        else begin
                            $display("FAIL done_tag: got %h expected %h", done_tag, e.tag);
                            errors++;
                        end
                    assert (done_crf == e.crf)
                        else begin
                            $display("FAIL done_crf: got %h expected %h", done_crf, e.crf);
                            errors++;
                        end
                    assert (done_result == e.field)
                        else begin
                            $display("FAIL done_result: got %h expected %h", done_result,
                                     e.field);
                            errors++;
                        end
                    shadow_cr[e.crf*4 +: 4] = e.field;
                    seen_results.push_back(done_result);
                    retired_cnt++;
                end
            end
            if (instr_valid && instr_ready) begin
                exp_q.push_back({tag, instr[6:8], cr_expect(instr, ra_value, rb_value, xer_so)});
                issued_cnt++;
            end
        end
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d results outstanding", cycles, exp_q.size());
        $display("Regression failed");
        $finish;
    end

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        tag         = '0;
        ra_value    = '0;
        rb_value    = '0;
        xer_so      = 1'b0;
        done_ready  = 1'b1;
        rst         = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (cr == 32'h0 && !done_valid)
            else begin
                $display("CR or result valid not cleared by reset");
                errors++;
            end
        @(posedge clk);
        #1;

        // Edge pairs first, then random pairs with every fifth pair equal.
        pair_a[0] = 32'h8000_0000;
        pair_b[0] = 32'h7fff_ffff;
        pair_a[1] = 32'h7fff_ffff;
        pair_b[1] = 32'h8000_0000;
        pair_a[2] = 32'hffff_ffff;
        pair_b[2] = 32'h0000_0000;
        pair_a[3] = 32'h0000_0000;
        pair_b[3] = 32'h0000_0000;
        for (int i = 4; i < 60; i++) begin
            pair_a[i] = $random(seed);
            pair_b[i] = (i % 5 == 0) ? pair_a[i] : $random(seed);
        end

        start_test();
        for (int i = 0; i < 60; i++) send_cmp(enc_xform(10'd0, i % 8), pair_a[i], pair_b[i], 1'b0);
        finish_test("signed cmp");
        signed_results = seen_results;

        start_test();
        for (int i = 0; i < 60; i++) send_cmp(enc_xform(10'd32, i % 8), pair_a[i], pair_b[i], 1'b0);
        finish_test("unsigned cmpl");
        for (int i = 0; i < 60; i++) begin
            if (pair_a[i][0] != pair_b[i][0] && i < seen_results.size()) begin
                assert (signed_results[i][0:1] == ~seen_results[i][0:1])
                    else begin
                        $display("Signed and unsigned order agree for pair %0d", i);
                        errors++;
                    end
            end
        end

        start_test();
        for (int i = 0; i < 30; i++) begin
            send_cmp(enc_dform(6'd11, i % 8, (i % 4 == 1) ? 16'h8000 : $random(seed)),
                     (i % 4 == 1) ? 32'hffff_8000 : $random(seed), '0, 1'b0);
            send_cmp(enc_dform(6'd10, i % 8, (i % 4 == 1) ? 16'hffff : $random(seed)),
                     (i % 4 == 1) ? 32'h0000_ffff : $random(seed), '0, 1'b0);
        end
        finish_test("immediate extension");

        start_test();
        for (int i = 0; i < 40; i++) send_random(i % 2);
        finish_test("summary overflow");

        start_test();
        ready_random = 1'b1;
        for (int i = 0; i < 64; i++) send_random($random(seed));
        ready_random = 1'b0;
        finish_test("back-pressure order");

        start_test();
        for (int i = 0; i < 16; i++) send_cmp(enc_dform(6'd10, i % 8, $random(seed)),
                                              $random(seed), '0, i[3]);
        finish_test("cr fields");

        start_test();
        apply_reset();
        @(negedge clk);
        assert (cr == 32'h0)
            else begin
                $display("FAIL cr: got %h expected %h", cr, 32'h0);
                errors++;
            end
        issued_cnt  = 0;
        retired_cnt = 0;
        @(posedge clk);
        #1;
        finish_test("reset");

        $display("Tests: %0d ok, %0d failed, %0d check errors, %0d property errors",
                 tests_ok, tests_bad, errors, UUT.u_unit.u_props.prop_errors);
        if (tests_bad == 0 && errors == 0 && UUT.u_unit.u_props.prop_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- cmp_subsystem.f
logic/ppc_instr_pkg.sv
logic/cr_types_pkg.sv
logic/cmp_issue_if.sv
logic/cmp_done_if.sv
logic/cmp_decoder.sv
logic/cmp_unit.sv
logic/cr_file.sv
logic/cmp_subsystem.sv
dv/cmp_clock_gen.sv
dv/cmp_unit_properties.sv
dv/cmp_tb.sv
